// File: Bender.yml
package:
  name: instr_fetch

sources:
  - verilog/fetch_pkg.sv
  - verilog/pc_generator.sv
  - verilog/branch_predictor.sv
  - verilog/instr_queue.sv
  - verilog/instr_fetch.sv
  - target: test
    files:
      - verification/fetch_asserts.sv
      - verification/tb_instr_fetch.sv

// File: sim.f
verilog/fetch_pkg.sv
verilog/pc_generator.sv
verilog/branch_predictor.sv
verilog/instr_queue.sv
verilog/instr_fetch.sv
verification/fetch_asserts.sv
verification/tb_instr_fetch.sv

// File: verification/fetch_asserts.sv
`timescale 1ns/1ps

module fetch_asserts import fetch_pkg::*; (
	input logic                          clk,
	input logic                          rst,
	input logic                          flush_pc,
	input logic                          flush_que,
	input logic                          queue_full,
	input logic [QUEUE_CNT_WIDTH-1:0]    queue_count,
	input fetch_memres_t                 icache_res,
	input fetch_memreq_t                 icache_req,
	input fetch_entry_t [FETCH_NUM-1:0]  fetch_entry
);

	int fail_count = 0;

	// the second entry continues where the first one predicted
	slot_order: assert property (@(posedge clk) disable iff (rst)
		fetch_entry[1].valid |-> fetch_entry[0].valid
			&& fetch_entry[1].vaddr == fetch_entry[0].branch_predict.predict_vaddr)
		else begin
			$error("slot 1 out of order with slot 0");
			fail_count++;
		end

	flush_empties: assert property (@(posedge clk) disable iff (rst)
		flush_pc |=> !fetch_entry[0].valid && !fetch_entry[1].valid)
		else begin
			$error("queue not empty after flush_pc");
			fail_count++;
		end

	// a stalled cache sees the same address again
	req_held: assert property (@(posedge clk) disable iff (rst)
		icache_res.stall && !flush_que && !$past(flush_que)
			|-> icache_req.vaddr == $past(icache_req.vaddr))
		else begin
			$error("cache request address changed during stall");
			fail_count++;
		end

	// a full queue never grows
	no_push_full: assert property (@(posedge clk) disable iff (rst)
		queue_full |=> queue_count <= $past(queue_count))
		else begin
			$error("push while queue full");
			fail_count++;
		end

endmodule

bind instr_fetch fetch_asserts asserts_inst (
	.clk         (clk),
	.rst         (rst),
	.flush_pc    (flush_pc),
	.flush_que   (flush_que),
	.queue_full  (queue_full),
	.queue_count (ique_inst.count),
	.icache_res  (icache_res),
	.icache_req  (icache_req),
	.fetch_entry (fetch_entry)
);

// File: verification/fetch_trace.txt
# M addr word | C cycle S stall_mask | C cycle B pc target cf
# E vaddr instr predicted_taken, in pop order
M bfc00000 24080001
M bfc00004 24090002
M bfc00008 01095020
M bfc0000c 254a0001
M bfc00014 1000fffd
C 12 S 0000002d
C 30 S 000000ff
C 0 B bfc00014 bfc0000c 1
E bfc00000 24080001 0
E bfc00004 24090002 0
E bfc00008 01095020 0
E bfc0000c 254a0001 0
E bfc00010 bfc0bfc9 0
E bfc00014 1000fffd 0
E bfc0000c 254a0001 0
E bfc00010 bfc0bfc9 0
E bfc00014 1000fffd 1
E bfc0000c 254a0001 0
E bfc00010 bfc0bfc9 0
E bfc00014 1000fffd 1
E bfc0000c 254a0001 0
E bfc00010 bfc0bfc9 0
E bfc00014 1000fffd 1

// File: verification/tb_instr_fetch.sv
`timescale 1ns/1ps

module tb_instr_fetch import fetch_pkg::*; ();

	localparam int MAX_CYCLES = 4096;

	logic                          clk;
	logic                          rst;
	logic                          flush_pc;
	logic                          stall_s2;
	branch_resolved_t              resolved_branch;
	fetch_memres_t                 icache_res;
	fetch_memreq_t                 icache_req;
	fetch_ack_t                    fetch_ack;
	fetch_entry_t [FETCH_NUM-1:0]  fetch_entry;

	// memory image
	virt_t        img_addr [$];
	logic [31:0]  img_word [$];
	// taken branches known to the back end
	virt_t        br_pc [$];
	virt_t        br_target [$];
	controlflow_t br_cf [$];
	int           br_from [$];
	// pop order
	virt_t        exp_vaddr [$];
	logic [31:0]  exp_instr [$];
	logic         exp_taken [$];
	logic         stall_map [MAX_CYCLES];

	integer seed;
	int     errors;
	int     assert_fails;
	int     timeouts;
	int     exp_idx;
	int     cycle;
	int     limit;
	logic   squash;
	int     redirect_br;

	instr_fetch DUT (
		.clk             (clk),
		.rst             (rst),
		.flush_pc        (flush_pc),
		.stall_s2        (stall_s2),
		.resolved_branch (resolved_branch),
		.icache_res      (icache_res),
		.icache_req      (icache_req),
		.fetch_ack       (fetch_ack),
		.fetch_entry     (fetch_entry)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] image_word(input virt_t addr);
		for (int i = 0; i < img_addr.size(); i++) begin
			if (img_addr[i] == addr) begin
				return img_word[i];
			end
		end
		return addr ^ 32'hbfd9;
	endfunction

	task automatic load_trace();
		int          fd;
		string       line;
		int          cyc;
		int          c;
		logic [31:0] a;
		logic [31:0] b;
		fd = $fopen("verification/fetch_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file");
			errors++;
			return;
		end
		while ($fgets(line, fd)) begin
			if (line.len() > 0) begin
				case (line[0])
					"M": begin
						void'($sscanf(line, "M %h %h", a, b));
						img_addr.push_back(a);
						img_word.push_back(b);
					end
					"C": begin
						if ($sscanf(line, "C %d S %h", cyc, a) == 2) begin
							for (int i = 0; i < 32; i++) begin
								if (a[i] && cyc + i < MAX_CYCLES) begin
									stall_map[cyc + i] = 1'b1;
								end
							end
						end else begin
							void'($sscanf(line, "C %d B %h %h %d", cyc, a, b, c));
							br_from.push_back(cyc);
							br_pc.push_back(a);
							br_target.push_back(b);
							br_cf.push_back(controlflow_t'(c[1:0]));
						end
					end
					"E": begin
						void'($sscanf(line, "E %h %h %d", a, b, c));
						exp_vaddr.push_back(a);
						exp_instr.push_back(b);
						exp_taken.push_back(c != 0);
					end
					default: begin
					end
				endcase
			end
		end
		$fclose(fd);
		if (exp_vaddr.size() == 0) begin
			$display("trace holds no expected pops");
			errors++;
		end
	endtask

	// younger entries in the same pop as a mispredicted branch are squashed
	task automatic check_pop(input fetch_entry_t e);
		if (squash || exp_idx >= exp_vaddr.size()) begin
			return;
		end
		assert (e.vaddr == exp_vaddr[exp_idx]) else begin
			$display("CHECK FAILED at %0t: pop %0d vaddr %h, expected %h",
				$time, exp_idx, e.vaddr, exp_vaddr[exp_idx]);
			errors++;
		end
		assert (e.instr == exp_instr[exp_idx] && e.instr == image_word(e.vaddr)) else begin
			$display("CHECK FAILED at %0t: pop %0d instr %h, expected %h",
				$time, exp_idx, e.instr, exp_instr[exp_idx]);
			errors++;
		end
		assert (e.branch_predict.taken == exp_taken[exp_idx]) else begin
			$display("CHECK FAILED at %0t: pop %0d predicted taken %b, expected %b",
				$time, exp_idx, e.branch_predict.taken, exp_taken[exp_idx]);
			errors++;
		end
		exp_idx++;
		for (int i = 0; i < br_pc.size(); i++) begin
			if (br_pc[i] == e.vaddr && cycle >= br_from[i]) begin
				if (!(e.branch_predict.taken && e.branch_predict.predict_vaddr == br_target[i])) begin
					squash      = 1'b1;
					redirect_br = i;
				end
			end
		end
	endtask

	// cache model and consumer, once per rising edge
	task automatic step_cycle();
		virt_t base;
		int    popped;
		int    avail;
		logic  flushing;
		logic  [31:0] r;
		base     = {icache_req.vaddr[31:3], 3'b000};
		flushing = flush_pc | (resolved_branch.valid & resolved_branch.mispredict);
		// requests are reads, flushed along with a redirect
		assert (icache_req.read && icache_req.flush == flushing) else begin
			$display("CHECK FAILED at %0t: cache request read %b flush %b, expected 1 and %b",
				$time, icache_req.read, icache_req.flush, flushing);
			errors++;
		end
		icache_res.stall    <= (cycle < MAX_CYCLES) ? stall_map[cycle] : 1'b0;
		icache_res.data     <= {image_word(base + 32'd4), image_word(base)};
		icache_res.iaddr_ex <= 1'b0;
		popped = stall_s2 ? 0 : int'(fetch_ack.num);
		avail  = 0;
		for (int i = 0; i < FETCH_NUM; i++) begin
			if (fetch_entry[i].valid) begin
				avail++;
			end
		end
		squash = 1'b0;
		for (int i = 0; i < popped; i++) begin
			check_pop(fetch_entry[i]);
		end
		avail    = flushing ? 0 : avail - popped;
		r        = $random(seed);
		stall_s2 <= (r[1:0] == 2'b00);
		if (squash) begin
			resolved_branch.valid      <= 1'b1;
			resolved_branch.pc         <= br_pc[redirect_br];
			resolved_branch.target     <= br_target[redirect_br];
			resolved_branch.taken      <= 1'b1;
			resolved_branch.mispredict <= 1'b1;
			resolved_branch.cf         <= br_cf[redirect_br];
			flush_pc                   <= 1'b1;
			fetch_ack.num              <= '0;
		end else begin
			resolved_branch <= '0;
			flush_pc        <= 1'b0;
			fetch_ack.num   <= FETCH_CNT_WIDTH'(r[9:2] % (avail + 1));
		end
		cycle++;
	endtask

	initial begin
		clk             = 1'b0;
		rst             = 1'b1;
		flush_pc        = 1'b0;
		stall_s2        = 1'b0;
		resolved_branch = '0;
		icache_res      = '0;
		fetch_ack       = '0;
		seed            = 32'hbfd9;
		errors          = 0;
		assert_fails    = 0;
		timeouts        = 0;
		exp_idx         = 0;
		cycle           = 0;
		squash          = 1'b0;
		redirect_br     = 0;
		for (int i = 0; i < MAX_CYCLES; i++) begin
			stall_map[i] = 1'b0;
		end
		load_trace();
		limit = 10 * exp_vaddr.size() + 200;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		forever begin
			@(posedge clk);
			step_cycle();
			if (exp_idx >= exp_vaddr.size() || cycle >= limit) begin
				if (exp_idx < exp_vaddr.size()) begin
					$display("timeout after %0d cycles with %0d of %0d pops seen",
						cycle, exp_idx, exp_vaddr.size());
					timeouts++;
				end
				assert_fails = DUT.asserts_inst.fail_count;
				$display("errors %0d, assertion failures %0d, timeouts %0d, pops checked %0d",
					errors, assert_fails, timeouts, exp_idx);
				if (errors == 0 && assert_fails == 0 && timeouts == 0) begin
					$display("TESTS PASSED");
				end else begin
					$display("TESTS FAILED");
				end
				$finish;
			end
		end
	end

endmodule

// File: verilog/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor import fetch_pkg::*; (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             hold,
	input  virt_t                            pc,
	input  logic            [FETCH_NUM-1:0]  instr_valid,
	input  branch_resolved_t                 resolved_branch,
	output logic                             valid,
	output virt_t                            predict_vaddr,
	output branch_predict_t [FETCH_NUM-1:0]  branch_predict
);

	typedef struct packed {
		logic [BTB_TAG_WIDTH-1:0] tag;
		virt_t                    target;
		controlflow_t             cf;
		logic [1:0]               cnt;
	} btb_entry_t;

	btb_entry_t              btb [BTB_SIZE];
	logic [BTB_SIZE-1:0]     btb_valid;

	// lookup side
	virt_t                   slot_pc [FETCH_NUM];
	logic [BTB_IDX_WIDTH-1:0] slot_idx [FETCH_NUM];
	btb_entry_t              rd_entry [FETCH_NUM];
	logic [FETCH_NUM-1:0]    hit;
	logic [FETCH_NUM-1:0]    slot_taken;
	logic                    found;

	// update side
	logic [BTB_IDX_WIDTH-1:0] upd_idx;
	logic [BTB_TAG_WIDTH-1:0] upd_tag;
	btb_entry_t              upd_old;
	btb_entry_t              upd_entry;
	logic                    upd_hit;
	logic                    upd_en;

	always_comb begin
		found         = 1'b0;
		predict_vaddr = '0;
		for (int i = 0; i < FETCH_NUM; i++) begin
			slot_pc[i]  = pc + virt_t'(i * 4);
			slot_idx[i] = slot_pc[i][2 +: BTB_IDX_WIDTH];
			rd_entry[i] = btb[slot_idx[i]];
			hit[i] = instr_valid[i] & btb_valid[slot_idx[i]]
				& (rd_entry[i].tag == slot_pc[i][31 -: BTB_TAG_WIDTH]);
			// jumps always go, branches follow the counter msb
			slot_taken[i] = hit[i] & ((rd_entry[i].cf == CF_JUMP) | rd_entry[i].cnt[1]);

			branch_predict[i].taken = slot_taken[i] & ~found;
			branch_predict[i].cf    = hit[i] ? rd_entry[i].cf : CF_NONE;
			branch_predict[i].predict_vaddr = branch_predict[i].taken ?
				rd_entry[i].target : slot_pc[i] + 32'd4;
			if (slot_taken[i] && !found) begin
				found         = 1'b1;
				predict_vaddr = rd_entry[i].target;
			end
		end
	end

	// no redirect while stage 2 is stuck
	assign valid = found & ~hold;

	assign upd_idx = resolved_branch.pc[2 +: BTB_IDX_WIDTH];
	assign upd_tag = resolved_branch.pc[31 -: BTB_TAG_WIDTH];
	assign upd_old = btb[upd_idx];
	assign upd_hit = btb_valid[upd_idx] & (upd_old.tag == upd_tag);
	// only taken branches get a new entry
	assign upd_en  = resolved_branch.valid & (resolved_branch.cf != CF_NONE)
		& (upd_hit | resolved_branch.taken);

	always_comb begin
		upd_entry.tag    = upd_tag;
		upd_entry.cf     = resolved_branch.cf;
		upd_entry.target = resolved_branch.taken ? resolved_branch.target : upd_old.target;
		if (!upd_hit) begin
			upd_entry.cnt = 2'd2;
		end else if (resolved_branch.taken) begin
			upd_entry.cnt = (upd_old.cnt == 2'd3) ? 2'd3 : upd_old.cnt + 2'd1;
		end else begin
			upd_entry.cnt = (upd_old.cnt == 2'd0) ? 2'd0 : upd_old.cnt - 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			btb_valid <= '0;
		end else if (upd_en) begin
			btb_valid[upd_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (upd_en) begin
			btb[upd_idx] <= upd_entry;
		end
	end

endmodule

// File: verilog/fetch_pkg.sv
package fetch_pkg;

	// fetch width
	localparam int FETCH_NUM        = 2;
	localparam int FETCH_CNT_WIDTH  = $clog2(FETCH_NUM + 1);
	localparam int ADDR_ALIGN_WIDTH = 3;

	// branch target buffer
	localparam int BTB_SIZE      = 8;
	localparam int BTB_IDX_WIDTH = $clog2(BTB_SIZE);
	localparam int BTB_TAG_WIDTH = 30 - BTB_IDX_WIDTH;

	// instruction queue
	localparam int QUEUE_DEPTH     = 8;
	localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);
	localparam int QUEUE_CNT_WIDTH = $clog2(QUEUE_DEPTH + 1);

	typedef logic [31:0] virt_t;

	localparam virt_t BOOT_VEC = 32'hbfc00000;

	typedef enum logic [1:0] {
		CF_NONE   = 2'd0,
		CF_BRANCH = 2'd1,
		CF_JUMP   = 2'd2
	} controlflow_t;

	typedef struct packed {
		logic         taken;
		controlflow_t cf;
		virt_t        predict_vaddr;
	} branch_predict_t;

	typedef struct packed {
		logic         valid;
		virt_t        pc;
		virt_t        target;
		logic         taken;
		logic         mispredict;
		controlflow_t cf;
	} branch_resolved_t;

	typedef struct packed {
		logic  read;
		virt_t vaddr;
		logic  flush;
	} fetch_memreq_t;

	typedef struct packed {
		logic        stall;
		logic [63:0] data;
		logic        iaddr_ex;
	} fetch_memres_t;

	typedef struct packed {
		logic            valid;
		virt_t           vaddr;
		logic [31:0]     instr;
		logic            iaddr_ex;
		branch_predict_t branch_predict;
	} fetch_entry_t;

	typedef struct packed {
		logic [FETCH_CNT_WIDTH-1:0] num;
	} fetch_ack_t;

	// clear the offset bits inside a fetch group
	function automatic virt_t align_fetch(input virt_t addr);
		return {addr[31:ADDR_ALIGN_WIDTH], {ADDR_ALIGN_WIDTH{1'b0}}};
	endfunction

endpackage

// File: verilog/instr_fetch.sv
`timescale 1ns/1ps

module instr_fetch import fetch_pkg::*; (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          flush_pc,
	input  logic                          stall_s2,
	input  branch_resolved_t              resolved_branch,
	input  fetch_memres_t                 icache_res,
	output fetch_memreq_t                 icache_req,
	input  fetch_ack_t                    fetch_ack,
	output fetch_entry_t [FETCH_NUM-1:0]  fetch_entry
);

	// stage 1
	logic  hold_pc;
	logic  flush_que;
	virt_t pc;
	virt_t fetch_vaddr;

	// stage 2
	virt_t fetch_vaddr_d;
	virt_t aligned_vaddr_d;
	logic  invalid_push;
	logic  [ADDR_ALIGN_WIDTH-3:0] fetch_offset;
	logic  [FETCH_NUM-1:0] slot_valid;
	logic  after_taken;
	logic  queue_full;

	// prediction
	logic  predict_valid;
	virt_t predict_vaddr;
	branch_predict_t [FETCH_NUM-1:0] branch_predict;
	fetch_entry_t    [FETCH_NUM-1:0] push_entry;

	assign flush_que = flush_pc | (resolved_branch.valid & resolved_branch.mispredict);
	assign hold_pc   = (icache_res.stall | queue_full) & ~flush_que;

	// re-request the stage 2 address while held
	always_comb begin
		if (hold_pc) begin
			fetch_vaddr = fetch_vaddr_d;
		end else if (predict_valid) begin
			fetch_vaddr = predict_vaddr;
		end else begin
			fetch_vaddr = pc;
		end
	end

	assign icache_req.read  = 1'b1;
	assign icache_req.vaddr = align_fetch(fetch_vaddr);
	assign icache_req.flush = flush_que;

	pc_generator pc_gen_inst (
		.clk             (clk),
		.rst             (rst),
		.hold_pc         (hold_pc),
		.predict_valid   (predict_valid),
		.predict_vaddr   (predict_vaddr),
		.resolved_branch (resolved_branch),
		.pc              (pc)
	);

	// invalid_push marks stage 2 as dead until a fresh address is loaded
	always_ff @(posedge clk) begin
		if (rst) begin
			fetch_vaddr_d <= BOOT_VEC;
			invalid_push  <= 1'b1;
		end else if (flush_que) begin
			invalid_push <= 1'b1;
		end else if (!hold_pc) begin
			fetch_vaddr_d <= fetch_vaddr;
			invalid_push  <= 1'b0;
		end
	end

	assign aligned_vaddr_d = align_fetch(fetch_vaddr_d);
	assign fetch_offset    = fetch_vaddr_d[ADDR_ALIGN_WIDTH-1:2];

	always_comb begin
		for (int i = 0; i < FETCH_NUM; i++) begin
			slot_valid[i] = ~invalid_push & (i >= int'(fetch_offset));
		end
	end

	branch_predictor bp_inst (
		.clk             (clk),
		.rst             (rst),
		.hold            (hold_pc),
		.pc              (aligned_vaddr_d),
		.instr_valid     (slot_valid),
		.resolved_branch (resolved_branch),
		.valid           (predict_valid),
		.predict_vaddr   (predict_vaddr),
		.branch_predict  (branch_predict)
	);

	// unpack the memory word, drop slots behind a predicted taken one
	always_comb begin
		after_taken = 1'b0;
		for (int i = 0; i < FETCH_NUM; i++) begin
			push_entry[i].valid          = slot_valid[i] & ~after_taken;
			push_entry[i].vaddr          = aligned_vaddr_d + virt_t'(i * 4);
			push_entry[i].instr          = icache_res.data[i * 32 +: 32];
			push_entry[i].iaddr_ex       = icache_res.iaddr_ex;
			push_entry[i].branch_predict = branch_predict[i];
			after_taken = after_taken | (slot_valid[i] & branch_predict[i].taken);
		end
	end

	instr_queue ique_inst (
		.clk         (clk),
		.rst         (rst),
		.flush       (flush_que),
		.hold        (hold_pc),
		.stall_pop   (stall_s2),
		.push_entry  (push_entry),
		.full        (queue_full),
		.fetch_ack   (fetch_ack),
		.fetch_entry (fetch_entry)
	);

endmodule

// File: verilog/instr_queue.sv
`timescale 1ns/1ps

module instr_queue import fetch_pkg::*; (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          flush,
	input  logic                          hold,
	input  logic                          stall_pop,
	input  fetch_entry_t [FETCH_NUM-1:0]  push_entry,
	output logic                          full,
	input  fetch_ack_t                    fetch_ack,
	output fetch_entry_t [FETCH_NUM-1:0]  fetch_entry
);

	fetch_entry_t               mem [QUEUE_DEPTH];
	logic [QUEUE_PTR_WIDTH-1:0] rd_ptr;
	logic [QUEUE_PTR_WIDTH-1:0] wr_ptr;
	logic [QUEUE_CNT_WIDTH-1:0] count;

	logic                       push_en;
	logic [FETCH_CNT_WIDTH-1:0] push_num;
	logic [FETCH_CNT_WIDTH-1:0] pop_num;
	logic [QUEUE_PTR_WIDTH-1:0] wr_idx [FETCH_NUM];

	assign push_en = ~hold & ~flush;
	// consumer ack is ignored while the back end is stalled
	assign pop_num = stall_pop ? '0 : fetch_ack.num;

	// valid slots are packed together in slot order
	always_comb begin
		push_num = '0;
		for (int i = 0; i < FETCH_NUM; i++) begin
			wr_idx[i] = wr_ptr + QUEUE_PTR_WIDTH'(push_num);
			if (push_en && push_entry[i].valid) begin
				push_num = push_num + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < FETCH_NUM; i++) begin
			if (push_en && push_entry[i].valid) begin
				mem[wr_idx[i]] <= push_entry[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			rd_ptr <= rd_ptr + QUEUE_PTR_WIDTH'(pop_num);
			wr_ptr <= wr_ptr + QUEUE_PTR_WIDTH'(push_num);
			count  <= count + QUEUE_CNT_WIDTH'(push_num) - QUEUE_CNT_WIDTH'(pop_num);
		end
	end

	// keep room for one full fetch group
	assign full = count > QUEUE_CNT_WIDTH'(QUEUE_DEPTH - FETCH_NUM);

	// oldest entries first, valid from the count only
	always_comb begin
		for (int i = 0; i < FETCH_NUM; i++) begin
			fetch_entry[i]       = mem[rd_ptr + QUEUE_PTR_WIDTH'(i)];
			fetch_entry[i].valid = count > QUEUE_CNT_WIDTH'(i);
		end
	end

endmodule

// File: verilog/pc_generator.sv
`timescale 1ns/1ps

module pc_generator import fetch_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  logic             hold_pc,
	input  logic             predict_valid,
	input  virt_t            predict_vaddr,
	input  branch_resolved_t resolved_branch,
	output virt_t            pc
);

	logic  redirect;
	virt_t pc_next;

	assign redirect = resolved_branch.valid & resolved_branch.mispredict;

	always_comb begin
		if (redirect) begin
			// back end knows better, no delay slot so fall through is pc + 4
			if (resolved_branch.taken) begin
				pc_next = resolved_branch.target;
			end else begin
				pc_next = resolved_branch.pc + 32'd4;
			end
		end else if (hold_pc) begin
			pc_next = pc;
		end else if (predict_valid) begin
			// target is requested this cycle, continue after it
			pc_next = align_fetch(predict_vaddr) + 32'd8;
		end else begin
			pc_next = align_fetch(pc) + 32'd8;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= BOOT_VEC;
		end else begin
			pc <= pc_next;
		end
	end

endmodule
